/* rtl/host_bus_pkg.sv */
package host_bus_pkg;

    // ------------------------------
    // address spaces and registers
    // ------------------------------
    localparam logic [3:0] ADDR_MAIN  = 4'd0;     // board registers and external board
    localparam logic [3:0] ADDR_HUB   = 4'd1;     // hub quadlet memory

    localparam logic [3:0] REG_STATUS = 4'd0;     // tag and board id
    localparam logic [3:0] REG_WDOG   = 4'd3;     // watchdog period
    localparam logic [3:0] REG_IPADDR = 4'd11;    // ip address of this board

    localparam int HUB_BOARDS = 16;               // boards held in hub memory
    localparam int HUB_QUADS  = 4;                // quadlets per board block

    // sysclk cycles per watchdog period unit
    // small so the watchdog expires quickly in simulation
    localparam int WDOG_TICK_CYCLES = 4;

    localparam logic [15:0] STATUS_TAG = 16'hB0A2;  // upper half of status word

    // ------------------------------
    // register address views
    // ------------------------------
    typedef struct packed {
        logic [3:0] space;      // addr[15:12]
        logic [3:0] chan;       // channel
        logic [3:0] group;      // zero for board registers
        logic [3:0] index;      // register index
    } main_view_t;

    typedef struct packed {
        logic [3:0] space;      // same position as main view
        logic [5:0] pad;        // must be zero for hub writes
        logic [3:0] board;      // board block
        logic [1:0] quad;       // quadlet in block
    } hub_view_t;

    // one 16-bit address word seen two ways
    typedef union packed {
        main_view_t main;
        hub_view_t  hub;
    } reg_addr_u;

    // ------------------------------
    // bus structs
    // ------------------------------
    typedef struct packed {
        logic        wen;           // quadlet write strobe
        logic        blk_wen;       // block write strobe
        logic        blk_wstart;    // block write starting
        logic [15:0] waddr;
        logic [31:0] wdata;
    } host_write_t;

    typedef struct packed {
        logic [15:0] raddr;
        logic        blk_rt_rd;     // real-time block read in progress
        logic        req_blk_rt_rd; // real-time block read requested
    } host_read_t;

    typedef struct packed {
        logic        wen;
        logic        blk_wen;
        logic        blk_wstart;
        logic [7:0]  waddr;         // short address of the block engine
        logic [31:0] wdata;
    } bw_write_t;

    typedef struct packed {
        logic        wen;
        logic [3:0]  waddr;
        logic [31:0] wdata;
    } rt_write_t;

endpackage

/* rtl/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter import host_bus_pkg::*; (
    input  host_write_t fw_wr,
    input  host_write_t eth_wr,
    input  host_read_t  fw_rd,
    input  host_read_t  eth_rd,
    input  logic        fw_req_write_bus,   // firewire is default owner
    input  logic        eth_req_write_bus,
    input  logic        eth_req_read_bus,
    input  logic        bw_write_en,        // block engine holds write bus
    input  bw_write_t   bw_wr,
    input  rt_write_t   fw_rt,
    input  rt_write_t   eth_rt,
    output host_write_t bus_wr,
    output reg_addr_u   bus_raddr,
    output logic        blk_rt_rd,
    output logic        req_blk_rt_rd,
    output rt_write_t   rt_wr
);

    // ------------------------------
    // write bus
    // ------------------------------
    always_comb begin
        if (bw_write_en) begin                      // block engine wins
            bus_wr.wen        = bw_wr.wen;
            bus_wr.blk_wen    = bw_wr.blk_wen;
            bus_wr.blk_wstart = bw_wr.blk_wstart;
            bus_wr.waddr      = {8'd0, bw_wr.waddr}; // zero-extend short address
            bus_wr.wdata      = bw_wr.wdata;
        end else if (eth_req_write_bus) begin
            bus_wr = eth_wr;
        end else begin
            bus_wr = fw_wr;                         // default owner
        end
    end

    // read bus goes to ethernet only while it asks
    assign bus_raddr     = eth_req_read_bus ? eth_rd.raddr : fw_rd.raddr;
    assign blk_rt_rd     = eth_req_read_bus ? eth_rd.blk_rt_rd : fw_rd.blk_rt_rd;
    assign req_blk_rt_rd = fw_rd.req_blk_rt_rd | eth_rd.req_blk_rt_rd;  // either host

    // real-time write channel
    assign rt_wr = eth_rt.wen ? eth_rt : fw_rt;

    // a shared write must come from a peer that holds the bus
    always_comb begin
        assert final (!bus_wr.wen || bw_write_en || eth_req_write_bus || fw_req_write_bus)
            else $error("bus_arbiter: write strobe with no bus owner");
    end

    // ethernet must not strobe while the block engine owns the bus
    always_comb begin
        assert final (!(bw_write_en && eth_req_write_bus && eth_wr.wen))
            else $error("bus_arbiter: ethernet write lost to block engine");
    end

endmodule

/* rtl/read_router.sv */
`timescale 1ns/10ps

module read_router import host_bus_pkg::*; (
    input  reg_addr_u   raddr,          // arbitrated read address
    input  logic [31:0] hub_rdata,      // hub quadlet memory
    input  logic [31:0] board_rdata,    // board registers
    input  logic [31:0] reg_rdata_ext,  // external board
    output logic [31:0] reg_rdata
);

    logic is_hub;   // hub space
    logic is_main;  // board register group

    // ------------------------------
    // address decode
    // ------------------------------

    // the space field sits in the same bits for both views
    assign is_hub  = (raddr.hub.space == ADDR_HUB);

    // board registers live in group 0 of the main space
    // other groups belong to the external board
    assign is_main = (raddr.main.space == ADDR_MAIN) &&
                     (raddr.main.group == 4'd0);

    // ------------------------------
    // data select
    // ------------------------------
    always_comb begin
        if (is_hub) begin
            reg_rdata = hub_rdata;
        end else if (is_main) begin
            reg_rdata = board_rdata;
        end else begin
            reg_rdata = reg_rdata_ext;  // unmapped spaces fall through too
        end
    end

endmodule

/* rtl/hub_regs.sv */
`timescale 1ns/10ps

module hub_regs import host_bus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  host_write_t bus_wr,         // shared write bus
    input  reg_addr_u   raddr,          // arbitrated read address
    input  logic [3:0]  board_id,       // rotary switch
    output logic [31:0] hub_rdata,
    output logic        hub_write_trig  // broadcast own block
);

    reg_addr_u   waddr;     // write address in hub view
    logic        hub_wen;   // write lands in hub memory
    logic        own_wr;    // write to last quad of own block

    // quadlets of all boards indexed by {board, quad}
    logic [31:0] hub_mem [HUB_BOARDS*HUB_QUADS];

    assign waddr = bus_wr.waddr;

    // ------------------------------
    // write decode
    // ------------------------------
    assign hub_wen = bus_wr.wen &&
                     (waddr.hub.space == ADDR_HUB) &&
                     (waddr.hub.pad == '0);     // rest of hub space unused

    assign own_wr = hub_wen &&
                    (waddr.hub.board == board_id) &&
                    (waddr.hub.quad == 2'(HUB_QUADS - 1));

    always_ff @(posedge sysclk) begin
        if (hub_wen)
            hub_mem[{waddr.hub.board, waddr.hub.quad}] <= bus_wr.wdata;
    end

    // async read for zero-latency register reads
    assign hub_rdata = hub_mem[{raddr.hub.board, raddr.hub.quad}];

    // ------------------------------
    // broadcast trigger
    // ------------------------------

    // last quad closes the block so the broadcast goes out one cycle later
    always_ff @(posedge sysclk) begin
        if (reset) begin
            hub_write_trig <= 1'b0;
        end else begin
            hub_write_trig <= own_wr;   // one pulse per block write
        end
    end

    // own block is written once per broadcast cycle
    a_trig_single: assert property (
        @(posedge sysclk) disable iff (reset)
        hub_write_trig |=> !hub_write_trig
    ) else $error("hub_regs: write trigger held two cycles");

endmodule

/* rtl/board_regs.sv */
`timescale 1ns/10ps

module board_regs import host_bus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  host_write_t bus_wr,         // shared write bus
    input  reg_addr_u   raddr,          // arbitrated read address
    input  logic [3:0]  board_id,
    input  logic [31:0] reg_rdata_ext,  // registers held by the external board
    input  logic        wdog_clear,     // clear timeout e.g. on power-up
    output logic [31:0] board_rdata,
    output logic        wdog_timeout    // sticky timeout flag
);

    reg_addr_u   waddr;
    logic        main_wen;      // any write to main space
    logic        board_wen;     // write to board register group
    logic        wdog_wen;      // write to REG_WDOG
    logic        wdog_restart;
    logic [15:0] wdog_period;   // 0 disables watchdog
    logic [31:0] wdog_count;
    logic [31:0] wdog_limit;    // cycles until timeout
    logic [31:0] ip_address;

    assign waddr = bus_wr.waddr;

    // ------------------------------
    // write decode
    // ------------------------------
    assign main_wen  = bus_wr.wen && (waddr.main.space == ADDR_MAIN);
    assign board_wen = main_wen && (waddr.main.chan == 4'd0) && (waddr.main.group == 4'd0);
    assign wdog_wen  = board_wen && (waddr.main.index == REG_WDOG);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            ip_address  <= 32'hFFFF_FFFF;               // unassigned
            wdog_period <= 16'd0;
        end else if (board_wen) begin
            if (waddr.main.index == REG_IPADDR)
                ip_address <= bus_wr.wdata;
            if (waddr.main.index == REG_WDOG)
                wdog_period <= bus_wr.wdata[15:0];      // upper bits ignored
        end
    end

    // ------------------------------
    // watchdog
    // ------------------------------

    // host traffic on main space keeps the watchdog fed
    assign wdog_restart = main_wen || wdog_clear;
    assign wdog_limit   = 32'(wdog_period) * WDOG_TICK_CYCLES;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_count   <= 32'd0;
            wdog_timeout <= 1'b0;
        end else begin
            if (wdog_restart)
                wdog_count <= 32'd0;
            else if (wdog_period != 16'd0 && !wdog_timeout)
                wdog_count <= wdog_count + 32'd1;       // stops once expired

            if (wdog_clear || wdog_wen)
                wdog_timeout <= 1'b0;
            else if (wdog_period != 16'd0 && wdog_count >= wdog_limit)
                wdog_timeout <= 1'b1;                   // holds until cleared
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        case (raddr.main.index)
            REG_STATUS: board_rdata = {STATUS_TAG, 12'd0, board_id};
            REG_WDOG:   board_rdata = {16'd0, wdog_period};
            REG_IPADDR: board_rdata = ip_address;
            default:    board_rdata = reg_rdata_ext;    // external board registers
        endcase
    end

    // count freezes one past the limit once the flag is up
    a_wdog_count_bound: assert property (
        @(posedge sysclk) disable iff (reset)
        wdog_count <= wdog_limit + 32'd1
    ) else $error("board_regs: watchdog count ran past its limit");

endmodule

/* rtl/host_bus_top.sv */
`timescale 1ns/10ps

module host_bus_top import host_bus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [3:0]  board_id,           // rotary switch

    // firewire host port
    input  host_write_t fw_wr,
    input  host_read_t  fw_rd,
    input  logic        fw_req_write_bus,
    input  rt_write_t   fw_rt,

    // ethernet host port
    input  host_write_t eth_wr,
    input  host_read_t  eth_rd,
    input  logic        eth_req_write_bus,
    input  logic        eth_req_read_bus,
    input  rt_write_t   eth_rt,

    // real-time block write engine
    input  logic        bw_write_en,
    input  bw_write_t   bw_wr,

    // external board and watchdog
    input  logic [31:0] reg_rdata_ext,
    input  logic        wdog_clear,

    // shared bus out
    output host_write_t bus_wr,
    output reg_addr_u   bus_raddr,
    output logic [31:0] reg_rdata,          // back to both hosts
    output logic        blk_rt_rd,
    output logic        req_blk_rt_rd,
    output rt_write_t   rt_wr,
    output logic        hub_write_trig,
    output logic        wdog_timeout
);

    logic [31:0] hub_rdata;     // hub memory read data
    logic [31:0] board_rdata;   // board register read data

    // ------------------------------
    // arbitration
    // ------------------------------
    bus_arbiter i_bus_arbiter (
        .fw_wr, .eth_wr, .fw_rd, .eth_rd,
        .fw_req_write_bus, .eth_req_write_bus, .eth_req_read_bus,
        .bw_write_en, .bw_wr, .fw_rt, .eth_rt,
        .bus_wr, .bus_raddr, .blk_rt_rd, .req_blk_rt_rd, .rt_wr
    );

    // ------------------------------
    // register peers
    // ------------------------------
    read_router i_read_router (
        .raddr(bus_raddr), .hub_rdata, .board_rdata, .reg_rdata_ext, .reg_rdata
    );

    hub_regs i_hub_regs (
        .sysclk, .reset, .bus_wr, .raddr(bus_raddr), .board_id,
        .hub_rdata, .hub_write_trig
    );

    board_regs i_board_regs (
        .sysclk, .reset, .bus_wr, .raddr(bus_raddr), .board_id,
        .reg_rdata_ext, .wdog_clear, .board_rdata, .wdog_timeout
    );

endmodule

/* testbench/host_bus_tb.sv */
`timescale 1ns/10ps

module host_bus_tb import host_bus_pkg::*; ();

    localparam logic [3:0] BOARD_ID = 4'd6;

    // one table row: peer stimulus and what the shared bus should show
    typedef struct packed {
        logic        bw_en;
        logic        eth_req_wr;
        logic        eth_req_rd;
        bw_write_t   bw_wr;
        host_write_t fw_wr;
        host_write_t eth_wr;
        host_read_t  fw_rd;
        host_read_t  eth_rd;
        rt_write_t   fw_rt;
        rt_write_t   eth_rt;
        logic [31:0] ext;           // external board read data
        host_write_t exp_wr;
        rt_write_t   exp_rt;
        reg_addr_u   exp_raddr;
        logic        exp_blk_rt_rd;
        logic        exp_req_blk;
        logic [31:0] exp_rdata;
    } row_t;

    logic        sysclk = 1'b0;
    logic        reset;
    logic [3:0]  board_id;
    host_write_t fw_wr, eth_wr, bus_wr;
    host_read_t  fw_rd, eth_rd;
    rt_write_t   fw_rt, eth_rt, rt_wr;
    bw_write_t   bw_wr;
    logic        fw_req_write_bus, eth_req_write_bus, eth_req_read_bus, bw_write_en;
    logic [31:0] reg_rdata_ext, reg_rdata;
    logic        wdog_clear, wdog_timeout, hub_write_trig;
    logic        blk_rt_rd, req_blk_rt_rd;
    reg_addr_u   bus_raddr;

    row_t        rows[$];
    string       names[$];
    logic [31:0] rnd = 32'h5219_3360;   // xorshift state
    bit          table_ready = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    host_bus_top i_host_bus_top (.*);

    always #10 sysclk = ~sysclk;        // 20 ns period

    // ------------------------------
    // random data and helpers
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_word();
        rnd = xorshift(rnd);
        return rnd;
    endfunction

    // idle row reading group 5 of main space, which belongs to the external board
    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.fw_rd.raddr = 16'h0050;
        r.exp_raddr = 16'h0050;
        r.ext = next_word();
        r.exp_rdata = r.ext;
        return r;
    endfunction

    // each row carries its own expected bus outputs
    task automatic add_row(input string name, input row_t r);
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        row_t        r;
        logic [31:0] hub_data;
        logic [31:0] ip_data;
        for (int k = 0; k < 4; k++) begin       // every bw / ethernet request pair
            r = blank_row();
            r.bw_en = k[1];
            r.eth_req_wr = k[0];
            r.fw_wr = '{1'b1, 1'b0, 1'b0, 16'h0120, next_word()};
            r.eth_wr = '{!(k[1] && k[0]), 1'b1, 1'b0, 16'h0230, next_word()};
            r.bw_wr = '{1'b1, 1'b1, 1'b1, 8'h45, next_word()};  // lands outside group 0
            if (k[1])                                   // block engine, address widened
                r.exp_wr = '{1'b1, 1'b1, 1'b1, 16'h0045, r.bw_wr.wdata};
            else if (k[0])
                r.exp_wr = r.eth_wr;
            else
                r.exp_wr = r.fw_wr;                     // default owner
            add_row($sformatf("write priority bw=%0d eth=%0d", k[1], k[0]), r);
        end
        r = blank_row();
        r.fw_rt = '{1'b1, 4'h2, next_word()};
        r.eth_rt = '{1'b1, 4'h9, next_word()};
        r.exp_rt = r.eth_rt;
        add_row("rt write ethernet first", r);
        r.eth_rt.wen = 1'b0;
        r.exp_rt = r.fw_rt;
        add_row("rt write firewire fallback", r);
        r = blank_row();
        r.eth_req_rd = 1'b1;
        r.eth_rd = '{{ADDR_MAIN, 8'h00, REG_STATUS}, 1'b1, 1'b0};
        r.fw_rd = '{16'h0050, 1'b0, 1'b1};
        r.exp_raddr = {ADDR_MAIN, 8'h00, REG_STATUS};
        r.exp_blk_rt_rd = 1'b1;
        r.exp_req_blk = 1'b1;                   // firewire request alone
        r.exp_rdata = {STATUS_TAG, 12'd0, BOARD_ID};
        add_row("read owner ethernet", r);
        r = blank_row();
        r.eth_rd = '{{ADDR_MAIN, 8'h00, REG_STATUS}, 1'b1, 1'b1};  // not asking, ignored
        r.exp_req_blk = 1'b1;                   // ethernet request alone
        add_row("read owner firewire", r);
        // ------------------------------
        hub_data = next_word();
        r = blank_row();
        r.fw_wr = '{1'b1, 1'b0, 1'b0, 16'h101D, hub_data};   // board 7 quad 1
        r.exp_wr = r.fw_wr;
        add_row("hub write", r);
        r = blank_row();
        r.fw_rd.raddr = 16'h101D;
        r.exp_raddr = 16'h101D;
        r.exp_rdata = hub_data;
        add_row("hub readback", r);
        r = blank_row();
        r.fw_rd.raddr = {ADDR_MAIN, 8'h00, REG_STATUS};
        r.exp_raddr = {ADDR_MAIN, 8'h00, REG_STATUS};
        r.exp_rdata = {STATUS_TAG, 12'd0, BOARD_ID};
        add_row("status word", r);
        ip_data = next_word();
        r = blank_row();
        r.fw_rd.raddr = {ADDR_MAIN, 8'h00, REG_IPADDR};
        r.fw_wr = '{1'b1, 1'b0, 1'b0, {ADDR_MAIN, 8'h00, REG_IPADDR}, ip_data};
        r.exp_wr = r.fw_wr;
        r.exp_raddr = {ADDR_MAIN, 8'h00, REG_IPADDR};
        r.exp_rdata = 32'hFFFF_FFFF;            // write not stored yet
        add_row("ip address reset value", r);
        r = blank_row();
        r.fw_rd.raddr = {ADDR_MAIN, 8'h00, REG_IPADDR};
        r.exp_raddr = {ADDR_MAIN, 8'h00, REG_IPADDR};
        r.exp_rdata = ip_data;
        add_row("ip address readback", r);
        r = blank_row();
        r.fw_rd.raddr = 16'h7000;
        r.exp_raddr = 16'h7000;
        add_row("unmapped space to external", r);
        add_row("main group 5 to external", blank_row());
    endtask

    // ------------------------------
    // drive and compare
    // ------------------------------
    task automatic drive(input row_t r);
        bw_write_en = r.bw_en;
        eth_req_write_bus = r.eth_req_wr;
        eth_req_read_bus = r.eth_req_rd;
        bw_wr = r.bw_wr;
        fw_wr = r.fw_wr;
        eth_wr = r.eth_wr;
        fw_rd = r.fw_rd;
        eth_rd = r.eth_rd;
        fw_rt = r.fw_rt;
        eth_rt = r.eth_rt;
        reg_rdata_ext = r.ext;
    endtask

    task automatic fw_write(input logic [15:0] addr, input logic [31:0] data);
        @(negedge sysclk);
        fw_wr = '{wen: 1'b1, blk_wen: 1'b0, blk_wstart: 1'b0, waddr: addr, wdata: data};
        @(negedge sysclk);
        fw_wr.wen = 1'b0;                       // single-cycle strobe
    endtask

    task automatic check_wr(input string what, input host_write_t got, input host_write_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s bus_wr got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_rt(input string what, input rt_write_t got, input rt_write_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s rt_wr got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_u got, input reg_addr_u exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        if (errors == e0)
            $display("test %s ok", name);
        else
            $display("test %s has %0d errors", name, errors - e0);
    endtask

    // ------------------------------
    // sequential tests
    // ------------------------------
    task automatic test_hub_trigger();
        int e0;
        e0 = errors;
        fw_write({ADDR_HUB, 6'd0, BOARD_ID, 2'd3}, next_word());    // closes own block
        #1;
        check_flag("trigger after own block write", hub_write_trig, 1'b1);
        @(negedge sysclk);
        #1;
        check_flag("trigger one cycle only", hub_write_trig, 1'b0);
        fw_write({ADDR_HUB, 6'd0, BOARD_ID, 2'd2}, next_word());
        #1;
        check_flag("trigger on quad 2", hub_write_trig, 1'b0);
        fw_write({ADDR_HUB, 6'd0, BOARD_ID + 4'd1, 2'd3}, next_word());  // other board
        #1;
        check_flag("trigger on other board", hub_write_trig, 1'b0);
        report("hub trigger", e0);
    endtask

    task automatic test_watchdog();
        int e0;
        int wait_cycles;
        e0 = errors;
        fw_write({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd5);   // 5 units of 4 cycles
        repeat (10) begin
            #1;
            check_flag("timeout during first 10 cycles", wdog_timeout, 1'b0);
            @(negedge sysclk);
        end
        wait_cycles = 10;
        while (!wdog_timeout && wait_cycles < 40) begin
            @(negedge sysclk);
            wait_cycles++;
        end
        checks++;
        if (wdog_timeout !== 1'b1) begin
            $display("watchdog flag did not rise within 40 cycles at period 5");
            errors++;
        end
        @(negedge sysclk);
        wdog_clear = 1'b1;
        @(negedge sysclk);
        wdog_clear = 1'b0;
        #1;
        check_flag("timeout after clear", wdog_timeout, 1'b0);
        fw_write({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd0);   // disabled
        repeat (40) begin
            @(negedge sysclk);
            #1;
            check_flag("timeout at period 0", wdog_timeout, 1'b0);
        end
        report("watchdog", e0);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int e0;
        build_table();
        table_ready = 1'b1;
        drive('0);
        fw_req_write_bus = 1'b1;        // firewire owns the bus by default
        wdog_clear = 1'b0;
        board_id = BOARD_ID;
        reset = 1'b1;
        repeat (8) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;
        foreach (rows[i]) begin
            e0 = errors;
            @(negedge sysclk);
            drive(rows[i]);
            #5;                         // outputs settled, well before the rising edge
            check_wr(names[i], bus_wr, rows[i].exp_wr);
            check_rt(names[i], rt_wr, rows[i].exp_rt);
            check_addr({names[i], " bus_raddr"}, bus_raddr, rows[i].exp_raddr);
            check_flag({names[i], " blk_rt_rd"}, blk_rt_rd, rows[i].exp_blk_rt_rd);
            check_flag({names[i], " req_blk_rt_rd"}, req_blk_rt_rd, rows[i].exp_req_blk);
            check_data({names[i], " reg_rdata"}, reg_rdata, rows[i].exp_rdata);
            report(names[i], e0);
        end
        @(negedge sysclk);
        drive('0);
        test_hub_trigger();
        test_watchdog();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // run limit scales with the table length
    initial begin
        wait (table_ready);
        #((rows.size() + 200) * 20);
        $display("simulation ran past its time limit and was stopped");
        $display("Checks failed");
        $finish;
    end

endmodule

/* host_bus.f */
rtl/host_bus_pkg.sv
rtl/bus_arbiter.sv
rtl/read_router.sv
rtl/hub_regs.sv
rtl/board_regs.sv
rtl/host_bus_top.sv
testbench/host_bus_tb.sv

/* Makefile */
SIM = obj_dir/host_bus_sim

.PHONY: all lint clean

all: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

$(SIM): host_bus.f $(wildcard rtl/*.sv testbench/*.sv)
	verilator --binary --timing --assert -j 0 \
		--top-module host_bus_tb -f host_bus.f -o host_bus_sim

lint:
	verilator --lint-only --timing -Wall --top-module host_bus_tb -f host_bus.f

clean:
	rm -rf obj_dir
